// File: include/uart_consts.svh
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// default bit period in clk cycles
`define UART_CLKS_PER_BIT 434

// data bits per serial frame
`define UART_DATA_BITS 8

// host command width
`define UART_CMD_BITS 16

`endif

// File: rtl/uart_pkg.sv
`include "uart_consts.svh"

package uart_pkg;

  // one frame's data byte
  typedef logic [`UART_DATA_BITS-1:0] uart_byte_t;

  // read flag on top of the address and data payload
  typedef struct packed {
    logic                      rd;
    logic [`UART_CMD_BITS-2:0] payload;
  } uart_cmd_t;

  typedef enum logic [2:0] {
    CTRL_IDLE,
    CTRL_SEND_HI,
    CTRL_SEND_LO,
    CTRL_WAIT_REPLY,
    CTRL_DONE
  } ctrl_state_t;

endpackage

// File: rtl/uart_tx.sv
`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_tx #(
  parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 tx_start,
  input  uart_pkg::uart_byte_t tx_byte,
  output logic                 tx,
  output logic                 tx_busy
);

  localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);
  localparam int FRAME_BITS = `UART_DATA_BITS + 3;
  localparam logic [3:0] IDX_LAST = 4'(FRAME_BITS - 1);

  logic [FRAME_BITS-1:0] shift_q;
  logic [CNT_W-1:0]      cnt_q;
  logic [3:0]            idx_q;
  logic                  bit_end;
  logic                  parity;

  assign bit_end = (cnt_q == CNT_LAST);

  // odd parity over the data byte
  assign parity = ~^tx_byte;

  // bit period counter
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (!tx_busy || bit_end) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_busy <= 1'b0;
      idx_q   <= '0;
    end else if (!tx_busy) begin
      if (tx_start) begin
        tx_busy <= 1'b1;
        idx_q   <= '0;
      end
    end else if (bit_end) begin
      if (idx_q == IDX_LAST) begin
        tx_busy <= 1'b0;
      end else begin
        idx_q <= idx_q + 1'b1;
      end
    end
  end

  // stop, parity, data lsb first, start
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      shift_q <= '1;
    end else if (!tx_busy) begin
      if (tx_start) begin
        shift_q <= {1'b1, parity, tx_byte, 1'b0};
      end
    end else if (bit_end) begin
      // ones fill in behind so the line ends up idle
      shift_q <= {1'b1, shift_q[FRAME_BITS-1:1]};
    end
  end

  assign tx = shift_q[0];

endmodule

// File: rtl/uart_rx.sv
`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_rx #(
  parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 rx,
  output uart_pkg::uart_byte_t rx_byte,
  output logic                 rx_vld,
  output logic                 rx_perr
);

  import uart_pkg::*;

  localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] CNT_MID = CNT_W'((CLKS_PER_BIT - 1) / 2);
  localparam logic [3:0] IDX_DATA_LAST = 4'(`UART_DATA_BITS);
  localparam logic [3:0] IDX_PAR = 4'(`UART_DATA_BITS + 1);
  localparam logic [3:0] IDX_STOP = 4'(`UART_DATA_BITS + 2);

  logic             rx_meta;
  logic             rx_sync;
  logic             rx_prev;
  logic             busy_q;
  logic [CNT_W-1:0] cnt_q;
  logic [3:0]       idx_q;
  uart_byte_t       data_q;
  logic             par_q;
  logic             fall;
  logic             mid;
  logic             stop_ok;

  // two-flop synchronizer plus a third flop for the edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign fall    = rx_prev & ~rx_sync;
  assign mid     = busy_q && (cnt_q == CNT_MID);
  assign stop_ok = mid && (idx_q == IDX_STOP) && rx_sync;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (!busy_q || cnt_q == CNT_LAST) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      idx_q  <= '0;
    end else if (!busy_q) begin
      if (fall) begin
        busy_q <= 1'b1;
        idx_q  <= '0;
      end
    end else if (mid && idx_q == 4'd0 && rx_sync) begin
      // glitch rather than a real start bit
      busy_q <= 1'b0;
    end else if (mid && idx_q == IDX_STOP) begin
      busy_q <= 1'b0;
    end else if (cnt_q == CNT_LAST) begin
      idx_q <= idx_q + 1'b1;
    end
  end

  // data arrives lsb first
  always_ff @(posedge clk) begin
    if (mid && idx_q >= 4'd1 && idx_q <= IDX_DATA_LAST) begin
      data_q <= {rx_sync, data_q[`UART_DATA_BITS-1:1]};
    end
    if (mid && idx_q == IDX_PAR) begin
      par_q <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_vld <= 1'b0;
    end else begin
      rx_vld <= stop_ok;
    end
  end

  always_ff @(posedge clk) begin
    if (stop_ok) begin
      rx_byte <= data_q;
      rx_perr <= ~(^{data_q, par_q});
    end
  end

endmodule

// File: rtl/uart_cmd_ctrl.sv
`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_cmd_ctrl (
  input  logic                 clk,
  input  logic                 rst_n,
  input  uart_pkg::uart_cmd_t  cmd,
  input  logic                 cmd_vld,
  output logic                 cmd_rdy,
  output logic                 tx_start,
  output uart_pkg::uart_byte_t tx_byte,
  input  logic                 tx_busy,
  input  uart_pkg::uart_byte_t rx_byte,
  input  logic                 rx_vld,
  input  logic                 rx_perr,
  output uart_pkg::uart_byte_t read_data,
  output logic                 read_err,
  output logic                 read_vld
);

  import uart_pkg::*;

  ctrl_state_t state_q;
  ctrl_state_t state_d;
  uart_cmd_t   cmd_q;
  logic        sent_q;
  logic        sending;
  logic        frame_done;
  logic        reply_take;

  assign cmd_rdy    = (state_q == CTRL_IDLE);
  assign sending    = (state_q == CTRL_SEND_HI) || (state_q == CTRL_SEND_LO);
  assign tx_start   = sending && !sent_q && !tx_busy;
  assign frame_done = sending && sent_q && !tx_busy;
  assign reply_take = (state_q == CTRL_WAIT_REPLY) && rx_vld;

  // high byte goes out first
  assign tx_byte = (state_q == CTRL_SEND_LO) ? cmd_q[`UART_DATA_BITS-1:0] :
                   cmd_q[`UART_CMD_BITS-1 -: `UART_DATA_BITS];

  always_comb begin
    state_d = state_q;
    case (state_q)
      CTRL_IDLE: begin
        if (cmd_vld && cmd_rdy) begin
          state_d = CTRL_SEND_HI;
        end
      end
      CTRL_SEND_HI: begin
        if (frame_done) begin
          state_d = CTRL_SEND_LO;
        end
      end
      CTRL_SEND_LO: begin
        if (frame_done) begin
          if (cmd_q.rd) begin
            state_d = CTRL_WAIT_REPLY;
          end else begin
            state_d = CTRL_DONE;
          end
        end
      end
      CTRL_WAIT_REPLY: begin
        if (rx_vld) begin
          state_d = CTRL_IDLE;
        end
      end
      default: state_d = CTRL_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= CTRL_IDLE;
      sent_q   <= 1'b0;
      read_vld <= 1'b0;
    end else begin
      state_q  <= state_d;
      read_vld <= reply_take;
      // one start pulse per frame
      if (state_d != state_q) begin
        sent_q <= 1'b0;
      end else if (tx_start) begin
        sent_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_vld && cmd_rdy) begin
      cmd_q <= cmd;
    end
    if (reply_take) begin
      read_data <= rx_byte;
      read_err  <= rx_perr;
    end
  end

endmodule

// File: rtl/uart_cmd_top.sv
`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_cmd_top #(
  parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  uart_pkg::uart_cmd_t  cmd,
  input  logic                 cmd_vld,
  output logic                 cmd_rdy,
  output logic                 tx,
  input  logic                 rx,
  output uart_pkg::uart_byte_t read_data,
  output logic                 read_err,
  output logic                 read_vld
);

  import uart_pkg::*;

  logic       tx_start;
  logic       tx_busy;
  uart_byte_t tx_byte;
  uart_byte_t rx_byte;
  logic       rx_vld;
  logic       rx_perr;

  uart_cmd_ctrl i_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd      (cmd),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_busy  (tx_busy),
    .rx_byte  (rx_byte),
    .rx_vld   (rx_vld),
    .rx_perr  (rx_perr),
    .read_data(read_data),
    .read_err (read_err),
    .read_vld (read_vld)
  );

  uart_tx #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) i_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_start(tx_start),
    .tx_byte (tx_byte),
    .tx      (tx),
    .tx_busy (tx_busy)
  );

  uart_rx #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) i_rx (
    .clk    (clk),
    .rst_n  (rst_n),
    .rx     (rx),
    .rx_byte(rx_byte),
    .rx_vld (rx_vld),
    .rx_perr(rx_perr)
  );

endmodule

// File: tests/uart_cmd_asserts.sv
`timescale 1ns/1ps

module uart_cmd_asserts (
  input logic clk,
  input logic rst_n,
  input logic cmd_vld,
  input logic cmd_rdy,
  input logic tx,
  input logic tx_busy,
  input logic read_vld
);

  a_read_vld_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    read_vld |=> !read_vld)
    else $error("read_vld held high for more than one cycle");

  // accepted command makes the controller busy
  a_rdy_drops: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_vld && cmd_rdy |=> !cmd_rdy)
    else $error("cmd_rdy still high after an accepted command");

  // a frame on the line belongs to an operation in progress
  a_rdy_low_busy: assert property (@(posedge clk) disable iff (!rst_n)
    tx_busy |-> !cmd_rdy)
    else $error("cmd_rdy high while a frame is being sent");

  a_rdy_with_result: assert property (@(posedge clk) disable iff (!rst_n)
    read_vld |-> cmd_rdy)
    else $error("read result returned while the controller is busy");

  // idle controller means idle transmitter
  a_tx_idle: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_rdy |-> tx)
    else $error("tx low while the link is idle");

  a_tx_high_unbusy: assert property (@(posedge clk) disable iff (!rst_n)
    !tx_busy |-> tx)
    else $error("tx low while the transmitter is idle");

endmodule

bind uart_cmd_top uart_cmd_asserts i_asserts (
  .clk     (clk),
  .rst_n   (rst_n),
  .cmd_vld (cmd_vld),
  .cmd_rdy (cmd_rdy),
  .tx      (tx),
  .tx_busy (tx_busy),
  .read_vld(read_vld)
);

// File: tests/uart_cmd_tb.sv
`timescale 1ns/1ps

module uart_cmd_tb;

  localparam int CLK_PERIOD   = 4;
  localparam int BIT_CLKS     = 8;
  localparam int HALF_BIT     = BIT_CLKS / 2;
  localparam int RESET_CYCLES = 3;
  localparam int N_TESTS      = 8;
  localparam int WATCHDOG_NS  = N_TESTS * 40 * BIT_CLKS * CLK_PERIOD;

  logic        clk = 1'b0;
  logic        rst_n;
  logic [15:0] cmd;
  logic        cmd_vld;
  logic        cmd_rdy;
  logic        tx;
  logic        rx;
  logic [7:0]  read_data;
  logic        read_err;
  logic        read_vld;

  // stimulus and expected results
  string       t_name    [N_TESTS];
  logic [15:0] t_cmd     [N_TESTS];
  logic [7:0]  t_reply   [N_TESTS];
  logic        t_bad_par [N_TESTS];
  logic [7:0]  t_exp_data[N_TESTS];
  logic        t_exp_err [N_TESTS];

  string       cur_name = "reset";
  int          n_checks = 0;
  int          n_errors = 0;
  int          rd_count = 0;
  logic [7:0]  rd_data;
  logic        rd_err;
  logic [7:0]  tx_bytes[$];

  uart_cmd_top #(
    .CLKS_PER_BIT(BIT_CLKS)
  ) i_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd      (cmd),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .tx       (tx),
    .rx       (rx),
    .read_data(read_data),
    .read_err (read_err),
    .read_vld (read_vld)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("Fail %s: expected 0x%0h, got 0x%0h", what, exp, act);
    end
  endtask

  task automatic add_test(input int idx, input string name, input logic [15:0] c,
                          input logic [7:0] reply, input logic bad_par,
                          input logic [7:0] exp_data, input logic exp_err);
    t_name[idx]     = name;
    t_cmd[idx]      = c;
    t_reply[idx]    = reply;
    t_bad_par[idx]  = bad_par;
    t_exp_data[idx] = exp_data;
    t_exp_err[idx]  = exp_err;
  endtask

  task automatic fill_table();
    add_test(0, "write_mixed", 16'h25c3, 8'h00, 1'b0, 8'h00, 1'b0);
    add_test(1, "read_basic", 16'h8012, 8'h3c, 1'b0, 8'h3c, 1'b0);
    add_test(2, "read_bad_parity", 16'h8134, 8'ha7, 1'b1, 8'ha7, 1'b1);
    add_test(3, "write_zero", 16'h0000, 8'h00, 1'b0, 8'h00, 1'b0);
    add_test(4, "read_all_ones", 16'hffff, 8'hff, 1'b0, 8'hff, 1'b0);
    add_test(5, "write_ones", 16'h7fff, 8'h00, 1'b0, 8'h00, 1'b0);
    add_test(6, "read_zero_bad_parity", 16'h8000, 8'h00, 1'b1, 8'h00, 1'b1);
    add_test(7, "read_alternating", 16'hc0de, 8'h55, 1'b0, 8'h55, 1'b0);
  endtask

  // vld stays up for extra cycles after the transfer while cmd_rdy is low
  task automatic issue_cmd(input logic [15:0] c, input int hold);
    @(posedge clk);
    cmd     <= c;
    cmd_vld <= 1'b1;
    @(negedge clk);
    while (!cmd_rdy) @(negedge clk);
    @(posedge clk);
    @(negedge clk);
    check({cur_name, " cmd_rdy after accept"}, 32'd0, 32'(cmd_rdy));
    repeat (hold + 1) @(posedge clk);
    cmd_vld <= 1'b0;
  endtask

  // remote device reply with odd parity unless told to corrupt it
  task automatic send_frame(input logic [7:0] b, input logic bad_par);
    logic [10:0] f;
    logic        par;
    par = ~^b;
    if (bad_par) par = ~par;
    f = {1'b1, par, b, 1'b0};
    for (int i = 0; i < 11; i++) begin
      @(posedge clk);
      rx <= f[i];
      repeat (BIT_CLKS - 1) @(posedge clk);
    end
  endtask

  // decodes tx at bit mid-points
  initial begin : tx_line_decoder
    logic [10:0] bits;
    logic        tx_prev;
    tx_prev = 1'b1;
    forever begin
      @(negedge clk);
      if (rst_n === 1'b1 && tx_prev && !tx) begin
        repeat (HALF_BIT - 1) @(negedge clk);
        bits[0] = tx;
        for (int i = 1; i < 11; i++) begin
          repeat (BIT_CLKS) @(negedge clk);
          bits[i] = tx;
        end
        check({cur_name, " start bit"}, 32'd0, 32'(bits[0]));
        check({cur_name, " stop bit"}, 32'd1, 32'(bits[10]));
        check({cur_name, " odd parity"}, 32'd1, 32'(^bits[9:1]));
        tx_bytes.push_back(bits[8:1]);
      end
      tx_prev = tx;
    end
  end

  always @(negedge clk) begin
    if (rst_n === 1'b1 && read_vld) begin
      rd_count = rd_count + 1;
      rd_data  = read_data;
      rd_err   = read_err;
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin : main_flow
    logic [15:0] c;
    int          err_before;
    void'($urandom(96));
    fill_table();
    rst_n   = 1'b0;
    cmd     = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check("reset cmd_rdy", 32'd1, 32'(cmd_rdy));
    check("reset tx", 32'd1, 32'(tx));
    check("reset read_vld", 32'd0, 32'(read_vld));

    for (int i = 0; i < N_TESTS; i++) begin
      cur_name   = t_name[i];
      c          = t_cmd[i];
      err_before = n_errors;
      rd_count   = 0;
      tx_bytes.delete();
      repeat ($urandom_range(7, 0)) @(posedge clk);
      @(negedge clk);
      check({cur_name, " cmd_rdy before accept"}, 32'd1, 32'(cmd_rdy));
      issue_cmd(c, c[15] ? 0 : 4);
      if (c[15]) begin
        @(negedge clk);
        while (tx_bytes.size() < 2) @(negedge clk);
        repeat ($urandom_range(3, 1) * BIT_CLKS) @(posedge clk);
        send_frame(t_reply[i], t_bad_par[i]);
      end
      @(negedge clk);
      while (!cmd_rdy) @(negedge clk);
      // let the result monitor settle
      repeat (2) @(negedge clk);

      check({cur_name, " frame count"}, 32'd2, 32'(tx_bytes.size()));
      if (tx_bytes.size() == 2) begin
        check({cur_name, " high byte"}, 32'(c[15:8]), 32'(tx_bytes[0]));
        check({cur_name, " low byte"}, 32'(c[7:0]), 32'(tx_bytes[1]));
      end
      check({cur_name, " read_vld count"}, c[15] ? 32'd1 : 32'd0, 32'(rd_count));
      if (c[15] && rd_count == 1) begin
        check({cur_name, " read_data"}, 32'(t_exp_data[i]), 32'(rd_data));
        check({cur_name, " read_err"}, 32'(t_exp_err[i]), 32'(rd_err));
      end
      if (n_errors == err_before) begin
        $display("test %0d %s: ok", i, cur_name);
      end else begin
        $display("test %0d %s: %0d mismatch(es)", i, cur_name, n_errors - err_before);
      end
    end

    $display("%0d tests, %0d checks, %0d errors", N_TESTS, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: flist.f
+incdir+include
rtl/uart_pkg.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_cmd_ctrl.sv
rtl/uart_cmd_top.sv
tests/uart_cmd_asserts.sv
tests/uart_cmd_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = uart_cmd_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = TESTS FAILED
PASS_MSG  = TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
